//--- bench/breakout_tb.sv
module breakout_tb;
   import breakout_geom_pkg::*;
   import breakout_video_pkg::*;

   // expected colour travelling alongside its probe pixel
   typedef struct packed {
      logic   valid;
      coord_t x;
      coord_t y;
      rgb_t   rgb;
   } probe_t;

   localparam int pad_step = 3;
   localparam logic [7:0] ball_rows [8] = '{8'h3C, 8'h7E, 8'hFF, 8'hFF,
                                           8'hFF, 8'hFF, 8'h7E, 8'h3C};
   localparam int max_frames = 9500;
   localparam int probes_per_frame = 4;
   localparam int watchdog_time = max_frames * (probes_per_frame + 2) * 20 + 20000;

   logic   clk;
   logic   reset;
   logic   left;
   logic   right;
   logic   video_on;
   coord_t x;
   coord_t y;
   rgb_t   rgb;

   // reference game state
   coord_t      m_pad;
   ball_t       m_ball;
   brick_mask_t m_bricks;
   miss_count_t m_misses;
   brick_mask_t last_hits;

   probe_t exp_now;
   probe_t exp_d1;
   probe_t exp_d2;

   int          seed;
   int          checks;
   int          errors;
   int          tests;
   int          test_checks;
   int          test_errors;
   logic        found;
   miss_count_t seen_misses;
   coord_t      rx;
   coord_t      ry;

   breakout_top #(
      .pad_step (pad_step)
   ) dut (
      .clk      (clk),
      .reset    (reset),
      .left     (left),
      .right    (right),
      .video_on (video_on),
      .x        (x),
      .y        (y),
      .rgb      (rgb)
   );

   always #10 clk = ~clk;

   function automatic coord_t move_paddle(input coord_t pad, input logic l, input logic r);
      coord_t pad_end;
      pad_end = pad + pad_len - 10'd1;
      if (r && !l && (pad_end <= 10'd535))
         return pad + coord_t'(pad_step);
      if (l && !r && (pad >= 10'd95))
         return pad - coord_t'(pad_step);
      return pad;
   endfunction

   function automatic brick_mask_t brick_hits(input ball_t b, input brick_mask_t mask);
      brick_mask_t hits;
      coord_t      b_right;
      coord_t      b_bottom;
      int          idx;
      hits = '0;
      b_right = b.x + 10'd7;
      b_bottom = b.y + 10'd7;
      for (int lane = 0; lane < brick_lanes; lane++)
      begin
         for (int col = 0; col < brick_cols; col++)
         begin
            idx = lane * brick_cols + col;
            if (mask[idx] && (b.y < lane_bottom[lane]) && (b_bottom > lane_bottom[lane]) &&
                (b.x > brick_left[col]) && (b_right < brick_right[col]))
               hits[idx] = 1'b1;
         end
      end
      return hits;
   endfunction

   // first matching rule sets the direction and then each axis steps one pixel
   function automatic ball_t move_ball(input ball_t b, input coord_t pad, input logic use_pad,
                                       input logic hit, output logic fell);
      ball_t  n;
      coord_t b_right;
      coord_t b_bottom;
      n = b;
      fell = 1'b0;
      b_right = b.x + 10'd7;
      b_bottom = b.y + 10'd7;
      if (b.y <= 10'd105)
         n.dy = 2'sb01;
      else if (b.x < 10'd95)
         n.dx = 2'sb01;
      else if (b_right > 10'd540)
         n.dx = 2'sb11;
      else if ((b_bottom >= 10'd477) && (b.x >= 10'd95) && (b_right < 10'd535) &&
               (b.dy == 2'sb01))
      begin
         n.dy = 2'sb11;
         fell = 1'b1;
      end
      else if (use_pad && (pad <= b_right) && (b.x <= pad + 10'd59) && (b_bottom >= 10'd450))
         n.dy = 2'sb11;
      else if (hit)
         n.dy = 2'sb01;
      n.x = (n.dx == 2'sb01) ? b.x + 10'd1 : b.x - 10'd1;
      n.y = (n.dy == 2'sb01) ? b.y + 10'd1 : b.y - 10'd1;
      return n;
   endfunction

   function automatic rgb_t expected_rgb(input coord_t px, input coord_t py, input logic von);
      coord_t dx;
      coord_t dy;
      logic   wall;
      logic   box;
      logic   brick;
      logic   marker;
      logic   sprite;
      dx = px - m_ball.x;
      dy = py - m_ball.y;
      box = (px >= 10'd200) && (px <= 10'd440) && (py >= 10'd200) && (py <= 10'd385);
      wall = (py >= 10'd100) && (((px >= 10'd90) && (px <= 10'd95)) ||
                                 ((px >= 10'd535) && (px <= 10'd540)) ||
                                 ((py <= 10'd105) && (px >= 10'd90) && (px <= 10'd540)));
      sprite = (px >= m_ball.x) && (dx < 10'd8) && (py >= m_ball.y) && (dy < 10'd8) &&
               ball_rows[dy[2:0]][dx[2:0]];
      brick = 1'b0;
      for (int lane = 0; lane < brick_lanes; lane++)
         for (int col = 0; col < brick_cols; col++)
            if (m_bricks[lane * brick_cols + col] && (px >= brick_left[col]) &&
                (px <= brick_right[col]) && (py >= lane_top[lane]) && (py <= lane_bottom[lane]))
               brick = 1'b1;
      marker = 1'b0;
      for (int k = 0; k < 3; k++)
         if ((int'(m_misses) <= k) && (px >= marker_left[k]) && (px <= marker_right[k]) &&
             (py >= 10'd50) && (py <= 10'd65))
            marker = 1'b1;
      if (!von)
         return 12'h000;
      if (m_misses == 2'd3)
         return box ? 12'hAA0 : 12'h000;
      if (wall)
         return 12'hAAF;
      if ((py >= 10'd450) && (py <= 10'd454) && (px >= m_pad) && (px <= m_pad + 10'd59))
         return 12'hFFF;
      if (sprite)
         return 12'h0F0;
      if (brick)
         return 12'hFDF;
      if (marker)
         return 12'h00F;
      return 12'h111;
   endfunction

   // ball x at its next fall to paddle height when nothing stops it
   function automatic coord_t landing_x();
      ball_t       b;
      brick_mask_t mask;
      brick_mask_t hits;
      logic        fell;
      b = m_ball;
      mask = m_bricks;
      for (int i = 0; i < 3000; i++)
      begin
         if ((b.dy == 2'sb01) && (b.y + 10'd7 >= 10'd450))
            return b.x;
         hits = brick_hits(b, mask);
         b = move_ball(b, m_pad, 1'b0, hits != '0, fell);
         mask = mask & ~hits;
      end
      return b.x;
   endfunction

   // {left, right}
   function automatic logic [1:0] buttons_toward(input coord_t target);
      if (m_pad < target)
         return 2'b01;
      if (m_pad > target)
         return 2'b10;
      return 2'b00;
   endfunction

   task automatic check_rgb(input rgb_t got, input rgb_t want, input coord_t px,
                            input coord_t py);
      checks++;
      if (got !== want)
      begin
         errors++;
         $display("error rgb at x %0d y %0d: got %h, expected %h", px, py, got, want);
      end
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("%s", what);
   endtask

   task automatic idle_cycles(input int n);
      repeat (n)
      begin
         @(negedge clk);
         x = '0;
         y = '0;
         video_on = 1'b0;
         exp_now = '0;
      end
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      left = 1'b0;
      right = 1'b0;
      x = '0;
      y = '0;
      video_on = 1'b0;
      exp_now = '0;
      repeat (2) @(negedge clk);
      reset = 1'b0;
      m_pad = 10'd95;
      m_ball = '{x: 10'd319, y: 10'd239, dx: 2'sb01, dy: 2'sb01};
      m_bricks = '1;
      m_misses = '0;
      last_hits = '0;
   endtask

   task automatic probe_pixel(input coord_t px, input coord_t py, input logic von);
      @(negedge clk);
      x = px;
      y = py;
      video_on = von;
      exp_now = '{valid: 1'b1, x: px, y: py, rgb: expected_rgb(px, py, von)};
   endtask

   // tick position for one cycle while the model steps on the old state
   task automatic run_frame(input logic [1:0] buttons);
      logic fell;
      @(negedge clk);
      left = buttons[1];
      right = buttons[0];
      x = tick_x;
      y = tick_y;
      video_on = 1'b0;
      exp_now = '0;
      last_hits = brick_hits(m_ball, m_bricks);
      m_ball = move_ball(m_ball, m_pad, 1'b1, last_hits != '0, fell);
      m_pad = move_paddle(m_pad, buttons[1], buttons[0]);
      m_bricks = m_bricks & ~last_hits;
      if (fell && (m_misses != 2'd3))
         m_misses = m_misses + 2'd1;
      idle_cycles(1);
   endtask

   task automatic probe_bricks();
      for (int lane = 0; lane < brick_lanes; lane++)
         for (int col = 0; col < brick_cols; col++)
            probe_pixel(coord_t'((brick_left[col] + brick_right[col]) / 2),
                        coord_t'((lane_top[lane] + lane_bottom[lane]) / 2), 1'b1);
   endtask

   task automatic probe_markers();
      for (int k = 0; k < 3; k++)
         probe_pixel(marker_left[k] + 10'd5, 10'd57, 1'b1);
   endtask

   task automatic probe_paddle();
      probe_pixel(m_pad - 10'd1, 10'd452, 1'b1);
      probe_pixel(m_pad, 10'd452, 1'b1);
      probe_pixel(m_pad + 10'd59, 10'd452, 1'b1);
      probe_pixel(m_pad + 10'd60, 10'd452, 1'b1);
   endtask

   task automatic probe_ball();
      probe_pixel(m_ball.x + 10'd3, m_ball.y + 10'd3, 1'b1);
      probe_pixel(m_ball.x, m_ball.y, 1'b1);
      probe_pixel(m_ball.x + 10'd7, m_ball.y + 10'd7, 1'b1);
      probe_pixel(m_ball.x + 10'd3, m_ball.y - 10'd1, 1'b1);
   endtask

   task automatic finish_test(input string name);
      idle_cycles(3);
      tests++;
      $display("%s: %0d checks, %0d errors", name, checks - test_checks, errors - test_errors);
      test_checks = checks;
      test_errors = errors;
   endtask

   always @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         exp_d1 <= '0;
         exp_d2 <= '0;
      end
      else
      begin
         exp_d1 <= exp_now;
         exp_d2 <= exp_d1;
      end
   end

   // rgb lags its probe by two cycles and is stable in the low phase
   always @(negedge clk)
   begin
      if (exp_d2.valid)
         check_rgb(rgb, exp_d2.rgb, exp_d2.x, exp_d2.y);
   end

   initial
   begin
      #(watchdog_time);
      $display("watchdog expired before all tests finished");
      $display("test failed");
      $finish;
   end

   initial
   begin
      clk = 1'b0;
      seed = 20175;
      checks = 0;
      errors = 0;
      tests = 0;
      test_checks = 0;
      test_errors = 0;
      apply_reset();

      probe_pixel(10'd92, 10'd300, 1'b0);
      probe_pixel(10'd92, 10'd300, 1'b1);
      probe_pixel(10'd538, 10'd300, 1'b1);
      probe_pixel(10'd300, 10'd103, 1'b1);
      probe_pixel(10'd96, 10'd452, 1'b1);
      probe_pixel(10'd154, 10'd452, 1'b1);
      probe_pixel(10'd155, 10'd452, 1'b1);
      probe_pixel(10'd323, 10'd243, 1'b1);
      probe_pixel(10'd319, 10'd239, 1'b1);
      probe_pixel(10'd326, 10'd246, 1'b1);
      probe_bricks();
      probe_markers();
      probe_pixel(10'd300, 10'd300, 1'b1);
      finish_test("reset picture");

      repeat (135)
      begin
         run_frame(2'b01);
         probe_paddle();
      end
      repeat (135)
      begin
         run_frame(2'b10);
         probe_paddle();
      end
      repeat (5)
      begin
         run_frame(2'b11);
         probe_paddle();
      end
      finish_test("paddle moves");

      // ball brought down near the paddle so the probed frames include a paddle bounce
      for (int i = 0; (i < 1000) && !((m_ball.dy == 2'sb01) && (m_ball.y >= 10'd343)); i++)
         run_frame(buttons_toward(m_ball.x - 10'd26));

      // paddle follows the ball for some bounces
      repeat (200)
      begin
         run_frame(buttons_toward(m_ball.x - 10'd26));
         repeat (4)
         begin
            rx = m_ball.x - 10'd4 + coord_t'($unsigned($random(seed)) % 16);
            ry = m_ball.y - 10'd4 + coord_t'($unsigned($random(seed)) % 16);
            probe_pixel(rx, ry, 1'b1);
         end
      end
      finish_test("free motion");

      found = 1'b0;
      for (int i = 0; (i < 2000) && !found; i++)
      begin
         run_frame(buttons_toward(m_ball.x - 10'd26));
         found = (last_hits != '0);
      end
      if (!found)
         report_failure("the ball never hit a brick within 2000 frames");
      probe_bricks();
      repeat (3)
      begin
         run_frame(2'b00);
         probe_ball();
      end
      finish_test("brick hit");

      // paddle parked on the side away from where the ball will land
      apply_reset();
      seen_misses = m_misses;
      for (int i = 0; (i < 6000) && (m_misses != 2'd3); i++)
      begin
         run_frame(buttons_toward((landing_x() >= 10'd315) ? 10'd92 : 10'd479));
         if (m_misses != seen_misses)
         begin
            seen_misses = m_misses;
            probe_markers();
         end
      end
      if (m_misses != 2'd3)
         report_failure("game over was not reached within 6000 frames");
      probe_pixel(10'd320, 10'd300, 1'b1);
      probe_pixel(10'd200, 10'd200, 1'b1);
      probe_pixel(10'd440, 10'd385, 1'b1);
      probe_pixel(10'd199, 10'd300, 1'b1);
      probe_pixel(10'd92, 10'd300, 1'b1);
      probe_pixel(m_pad + 10'd10, 10'd452, 1'b1);
      probe_bricks();
      finish_test("floor misses");

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

//--- design/ball_motion.sv
module ball_motion (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       frame_tick,
   input  logic                       brick_hit,
   input  breakout_geom_pkg::paddle_t paddle,
   output breakout_geom_pkg::ball_t   ball,
   output logic                       floor_hit
);
   import breakout_geom_pkg::*;

   ball_t  ball_next;
   coord_t ball_right;
   coord_t ball_bottom;
   coord_t pad_right;
   logic   at_floor;
   logic   on_paddle;

   assign ball_right = ball.x + ball_size - 10'd1;
   assign ball_bottom = ball.y + ball_size - 10'd1;
   assign pad_right = paddle.left + pad_len - 10'd1;

   // floor only counts between the walls and while falling
   assign at_floor = (ball_bottom >= floor_y) && (ball.x >= wall_l_inner) &&
                     (ball_right < wall_r_inner) && (ball.dy == step_pos);
   assign on_paddle = (paddle.left <= ball_right) && (ball.x <= pad_right) &&
                      (ball_bottom >= pad_top);

   always_comb
   begin
      ball_next = ball;
      floor_hit = 1'b0;
      if (ball.y <= wall_bottom)
      begin
         ball_next.dy = step_pos;
      end
      else if (ball.x < wall_l_inner)
      begin
         ball_next.dx = step_pos;
      end
      else if (ball_right > wall_r_outer)
      begin
         ball_next.dx = step_neg;
      end
      else if (at_floor)
      begin
         ball_next.dy = step_neg;
         floor_hit = frame_tick;
      end
      else if (on_paddle)
      begin
         ball_next.dy = step_neg;
      end
      else if (brick_hit)
      begin
         ball_next.dy = step_pos;
      end
      // step with the new direction, sign extended
      ball_next.x = ball.x + {{8{ball_next.dx[1]}}, ball_next.dx};
      ball_next.y = ball.y + {{8{ball_next.dy[1]}}, ball_next.dy};
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         ball <= ball_reset;
      end
      else if (frame_tick)
      begin
         ball <= ball_next;
      end
   end

endmodule

//--- design/ball_sprite.sv
module ball_sprite (
   input  breakout_geom_pkg::ball_t  ball,
   input  breakout_geom_pkg::coord_t x,
   input  breakout_geom_pkg::coord_t y,
   output logic                      on
);
   import breakout_geom_pkg::*;

   coord_t     row_off;
   coord_t     col_off;
   logic       in_box;
   logic [7:0] row_bits;

   assign row_off = y - ball.y;
   assign col_off = x - ball.x;
   assign in_box = (x >= ball.x) && (col_off < ball_size) &&
                   (y >= ball.y) && (row_off < ball_size);

   // round shape, bit n is column offset n
   always_comb
   begin
      case (row_off[2:0])
         3'd0, 3'd7: row_bits = 8'h3C;
         3'd1, 3'd6: row_bits = 8'h7E;
         default:    row_bits = 8'hFF;
      endcase
   end

   assign on = in_box && row_bits[col_off[2:0]];

endmodule

//--- design/breakout_geom_pkg.sv
package breakout_geom_pkg;

   typedef logic [9:0] coord_t;
   typedef logic signed [1:0] delta_t;
   typedef logic [17:0] brick_mask_t;
   typedef logic [1:0] miss_count_t;

   localparam delta_t step_pos = 2'sb01;
   localparam delta_t step_neg = 2'sb11;

   typedef struct packed {
      coord_t x;
      coord_t y;
      delta_t dx;
      delta_t dy;
   } ball_t;

   typedef struct packed {
      coord_t left;
   } paddle_t;

   localparam coord_t x_max = 10'd639;
   localparam coord_t y_max = 10'd479;
   localparam coord_t tick_x = 10'd0;
   localparam coord_t tick_y = 10'd481;

   localparam coord_t wall_l_outer = 10'd90;
   localparam coord_t wall_l_inner = 10'd95;
   localparam coord_t wall_r_inner = 10'd535;
   localparam coord_t wall_r_outer = 10'd540;
   localparam coord_t wall_top = 10'd100;
   localparam coord_t wall_bottom = 10'd105;
   localparam coord_t floor_y = y_max - 10'd2;

   localparam coord_t pad_top = 10'd450;
   localparam coord_t pad_bottom = 10'd454;
   localparam coord_t pad_len = 10'd60;
   localparam paddle_t pad_reset = '{left: 10'd95};

   localparam coord_t ball_size = 10'd8;
   localparam ball_t ball_reset = '{x: x_max >> 1, y: y_max >> 1, dx: step_pos, dy: step_pos};

   localparam int brick_lanes = 3;
   localparam int brick_cols = 6;
   localparam coord_t brick_left [brick_cols] = '{98, 175, 252, 329, 406, 483};
   localparam coord_t brick_right [brick_cols] = '{170, 247, 324, 401, 478, 532};
   // index 0 is the lowest lane on screen (lane 3)
   localparam coord_t lane_top [brick_lanes] = '{137, 122, 107};
   localparam coord_t lane_bottom [brick_lanes] = '{149, 134, 119};

   localparam miss_count_t miss_limit = 2'd3;
   localparam int marker_count = 3;
   localparam coord_t marker_left [marker_count] = '{520, 540, 560};
   localparam coord_t marker_right [marker_count] = '{530, 550, 570};
   localparam coord_t marker_top = 10'd50;
   localparam coord_t marker_bottom = 10'd65;

   localparam coord_t over_left = 10'd200;
   localparam coord_t over_right = 10'd440;
   localparam coord_t over_top = 10'd200;
   localparam coord_t over_bottom = 10'd385;

endpackage

//--- design/breakout_top.sv
module breakout_top #(
   parameter int pad_step = 3
) (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      left,
   input  logic                      right,
   input  logic                      video_on,
   input  breakout_geom_pkg::coord_t x,
   input  breakout_geom_pkg::coord_t y,
   output breakout_video_pkg::rgb_t  rgb
);
   import breakout_geom_pkg::*;
   import breakout_video_pkg::*;

   pixel_t      pix;
   logic        frame_tick;
   paddle_t     paddle;
   ball_t       ball;
   logic        floor_hit;
   logic        brick_hit;
   brick_mask_t bricks;
   miss_count_t misses;

   frame_sync u_frame_sync (
      .clk        (clk),
      .reset      (reset),
      .video_on   (video_on),
      .x          (x),
      .y          (y),
      .pix        (pix),
      .frame_tick (frame_tick)
   );

   paddle_ctrl #(
      .pad_step (pad_step)
   ) u_paddle_ctrl (
      .clk        (clk),
      .reset      (reset),
      .frame_tick (frame_tick),
      .left       (left),
      .right      (right),
      .paddle     (paddle)
   );

   ball_motion u_ball_motion (
      .clk        (clk),
      .reset      (reset),
      .frame_tick (frame_tick),
      .brick_hit  (brick_hit),
      .paddle     (paddle),
      .ball       (ball),
      .floor_hit  (floor_hit)
   );

   field_state u_field_state (
      .clk        (clk),
      .reset      (reset),
      .frame_tick (frame_tick),
      .floor_hit  (floor_hit),
      .ball       (ball),
      .brick_hit  (brick_hit),
      .bricks     (bricks),
      .misses     (misses)
   );

   pixel_renderer u_pixel_renderer (
      .clk    (clk),
      .reset  (reset),
      .pix    (pix),
      .paddle (paddle),
      .ball   (ball),
      .bricks (bricks),
      .misses (misses),
      .rgb    (rgb)
   );

endmodule

//--- design/breakout_video_pkg.sv
package breakout_video_pkg;

   typedef logic [11:0] rgb_t;

   localparam rgb_t wall_rgb = 12'hAAF;
   localparam rgb_t paddle_rgb = 12'hFFF;
   localparam rgb_t brick_rgb = 12'hFDF;
   localparam rgb_t ball_rgb = 12'h0F0;
   localparam rgb_t back_rgb = 12'h111;
   localparam rgb_t marker_rgb = 12'h00F;
   localparam rgb_t over_rgb = 12'hAA0;
   localparam rgb_t blank_rgb = 12'h000;

   // scan position one cycle behind the input
   typedef struct packed {
      breakout_geom_pkg::coord_t x;
      breakout_geom_pkg::coord_t y;
      logic video_on;
   } pixel_t;

endpackage

//--- design/field_state.sv
module field_state (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           frame_tick,
   input  logic                           floor_hit,
   input  breakout_geom_pkg::ball_t       ball,
   output logic                           brick_hit,
   output breakout_geom_pkg::brick_mask_t bricks,
   output breakout_geom_pkg::miss_count_t misses
);
   import breakout_geom_pkg::*;

   brick_mask_t hits;
   coord_t      ball_right;
   coord_t      ball_bottom;
   logic        game_over;

   assign ball_right = ball.x + ball_size - 10'd1;
   assign ball_bottom = ball.y + ball_size - 10'd1;
   assign game_over = (misses == miss_limit);

   // ball straddles the lane bottom row and sits strictly inside the column
   always_comb
   begin
      hits = '0;
      for (int lane = 0; lane < brick_lanes; lane++)
      begin
         for (int col = 0; col < brick_cols; col++)
         begin
            hits[lane * brick_cols + col] = bricks[lane * brick_cols + col] &&
                                            (ball.y < lane_bottom[lane]) &&
                                            (lane_bottom[lane] < ball_bottom) &&
                                            (brick_left[col] < ball.x) &&
                                            (ball_right < brick_right[col]);
         end
      end
   end

   assign brick_hit = frame_tick && (hits != '0);

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         bricks <= '1;
         misses <= '0;
      end
      else if (frame_tick)
      begin
         bricks <= bricks & ~hits;
         // saturate at game over
         if (floor_hit && !game_over)
         begin
            misses <= misses + 2'd1;
         end
      end
   end

endmodule

//--- design/frame_sync.sv
module frame_sync (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       video_on,
   input  breakout_geom_pkg::coord_t  x,
   input  breakout_geom_pkg::coord_t  y,
   output breakout_video_pkg::pixel_t pix,
   output logic                       frame_tick
);
   import breakout_geom_pkg::*;
   import breakout_video_pkg::*;

   logic at_tick;
   logic held_tick;

   assign at_tick = (x == tick_x) && (y == tick_y);
   // previous position already at the tick, so a held position ticks only once
   assign held_tick = (pix.x == tick_x) && (pix.y == tick_y);

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         pix <= '0;
         frame_tick <= 1'b0;
      end
      else
      begin
         pix <= pixel_t'{x: x, y: y, video_on: video_on};
         frame_tick <= at_tick && !held_tick;
      end
   end

endmodule

//--- design/paddle_ctrl.sv
module paddle_ctrl #(
   parameter int pad_step = 3
) (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       frame_tick,
   input  logic                       left,
   input  logic                       right,
   output breakout_geom_pkg::paddle_t paddle
);
   import breakout_geom_pkg::*;

   coord_t step;
   coord_t pad_right;
   logic   move_right;
   logic   move_left;

   assign step = coord_t'(pad_step);
   assign pad_right = paddle.left + pad_len - 10'd1;

   // one button alone, and only while the end has not passed the wall edge
   assign move_right = right && !left && (pad_right <= wall_r_inner);
   assign move_left = left && !right && (paddle.left >= wall_l_inner);

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         paddle <= pad_reset;
      end
      else if (frame_tick)
      begin
         if (move_right)
         begin
            paddle.left <= paddle.left + step;
         end
         else if (move_left)
         begin
            paddle.left <= paddle.left - step;
         end
      end
   end

endmodule

//--- design/pixel_renderer.sv
module pixel_renderer (
   input  logic                           clk,
   input  logic                           reset,
   input  breakout_video_pkg::pixel_t     pix,
   input  breakout_geom_pkg::paddle_t     paddle,
   input  breakout_geom_pkg::ball_t       ball,
   input  breakout_geom_pkg::brick_mask_t bricks,
   input  breakout_geom_pkg::miss_count_t misses,
   output breakout_video_pkg::rgb_t       rgb
);
   import breakout_geom_pkg::*;
   import breakout_video_pkg::*;

   coord_t pad_right;
   logic   game_over;
   logic   over_on;
   logic   wall_on;
   logic   pad_on;
   logic   ball_on;
   logic   brick_on;
   logic   marker_on;
   rgb_t   colour;

   ball_sprite u_ball_sprite (
      .ball (ball),
      .x    (pix.x),
      .y    (pix.y),
      .on   (ball_on)
   );

   assign pad_right = paddle.left + pad_len - 10'd1;
   assign game_over = (misses == miss_limit);

   assign over_on = (pix.x >= over_left) && (pix.x <= over_right) &&
                    (pix.y >= over_top) && (pix.y <= over_bottom);

   // side walls run to the bottom of the screen
   assign wall_on = ((pix.x >= wall_l_outer) && (pix.x <= wall_l_inner) && (pix.y >= wall_top)) ||
                    ((pix.x >= wall_r_inner) && (pix.x <= wall_r_outer) && (pix.y >= wall_top)) ||
                    ((pix.y >= wall_top) && (pix.y <= wall_bottom) &&
                     (pix.x >= wall_l_outer) && (pix.x <= wall_r_outer));

   assign pad_on = (pix.y >= pad_top) && (pix.y <= pad_bottom) &&
                   (pix.x >= paddle.left) && (pix.x <= pad_right);

   always_comb
   begin
      brick_on = 1'b0;
      for (int lane = 0; lane < brick_lanes; lane++)
      begin
         for (int col = 0; col < brick_cols; col++)
         begin
            if (bricks[lane * brick_cols + col] &&
                (pix.x >= brick_left[col]) && (pix.x <= brick_right[col]) &&
                (pix.y >= lane_top[lane]) && (pix.y <= lane_bottom[lane]))
            begin
               brick_on = 1'b1;
            end
         end
      end
   end

   // marker k stays lit until the miss count passes k
   always_comb
   begin
      marker_on = 1'b0;
      for (int k = 0; k < marker_count; k++)
      begin
         if ((misses <= miss_count_t'(k)) &&
             (pix.x >= marker_left[k]) && (pix.x <= marker_right[k]) &&
             (pix.y >= marker_top) && (pix.y <= marker_bottom))
         begin
            marker_on = 1'b1;
         end
      end
   end

   always_comb
   begin
      if (!pix.video_on)
         colour = blank_rgb;
      else if (game_over)
         colour = over_on ? over_rgb : blank_rgb;
      else if (wall_on)
         colour = wall_rgb;
      else if (pad_on)
         colour = paddle_rgb;
      else if (ball_on)
         colour = ball_rgb;
      else if (brick_on)
         colour = brick_rgb;
      else if (marker_on)
         colour = marker_rgb;
      else
         colour = back_rgb;
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         rgb <= blank_rgb;
      end
      else
      begin
         rgb <= colour;
      end
   end

endmodule

//--- project.f
design/breakout_geom_pkg.sv
design/breakout_video_pkg.sv
design/frame_sync.sv
design/paddle_ctrl.sv
design/ball_motion.sv
design/field_state.sv
design/ball_sprite.sv
design/pixel_renderer.sv
design/breakout_top.sv
bench/breakout_tb.sv

//--- run.sh
#!/bin/sh
# build and run the breakout testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal --top-module breakout_tb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vbreakout_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "test passed" "$log"; then
   exit 0
else
   echo "pass message not found in $log"
   exit 1
fi
